/* rtl/eth_pkg.sv */
package eth_pkg;

  // ==========================================================================
  // Address and field widths
  // ==========================================================================

  typedef logic [5:0][7:0] mac_addr_t;   // Byte 5 goes out first on the wire.
  typedef logic [3:0][7:0] ipv4_addr_t;
  typedef logic [15:0]     ethertype_t;
  typedef logic [15:0]     length_t;

  // One byte of a frame stream.
  typedef struct packed {
    logic       val;
    logic       sof;
    logic       eof;
    logic [7:0] dat;
  } stream_t;

  typedef struct packed {
    mac_addr_t  mac_addr;
    ipv4_addr_t ipv4_addr;
  } dev_t;

  // Frame header handed to the MAC together with tx_rdy.
  typedef struct packed {
    mac_addr_t  dst_mac;
    mac_addr_t  src_mac;
    ethertype_t ethertype;
    length_t    length;
  } mac_meta_t;

  localparam ethertype_t ETHERTYPE_ARP   = 16'h0806;
  localparam length_t    MIN_PAYLOAD_LEN = 16'd46;
  localparam mac_addr_t  BROADCAST_MAC   = '1;

endpackage : eth_pkg

/* rtl/arp_pkg.sv */
package arp_pkg;

  localparam int ARP_HDR_LEN = 28;  // Bytes, for IPv4 over Ethernet.

  typedef logic [15:0] arp_oper_t;

  localparam arp_oper_t OPER_REQUEST = 16'd1;
  localparam arp_oper_t OPER_REPLY   = 16'd2;

  // The protocol type field shares the ethertype number space.
  localparam eth_pkg::ethertype_t PTYPE_IPV4 = 16'h0800;

  // ==========================================================================
  // Header fields kept from a received frame
  // ==========================================================================

  typedef struct packed {
    arp_oper_t           oper;
    eth_pkg::mac_addr_t  sha;
    eth_pkg::ipv4_addr_t spa;
    eth_pkg::mac_addr_t  tha;
    eth_pkg::ipv4_addr_t tpa;
  } arp_hdr_t;

  // One frame for the transmitter. Sender fields always come from dev.
  typedef struct packed {
    arp_oper_t           oper;
    eth_pkg::mac_addr_t  dst_mac;  // Ethernet destination, not part of the ARP header.
    eth_pkg::mac_addr_t  tha;
    eth_pkg::ipv4_addr_t tpa;
  } arp_job_t;

endpackage : arp_pkg

/* rtl/arp_rx.sv */
`timescale 1ns/10ps

module arp_rx (
  input  logic              clk,
  input  logic              fsm_rst,
  input  eth_pkg::stream_t  rx_strm,
  output logic              hdr_val,
  output arp_pkg::arp_hdr_t rx_hdr
);

  localparam int         HDR_LEN   = arp_pkg::ARP_HDR_LEN;
  localparam logic [4:0] HDR_BYTES = 5'(arp_pkg::ARP_HDR_LEN);

  // Bytes collected in the current frame. Zero means waiting for sof,
  // HDR_BYTES means the header is done and the rest is skipped.
  logic [4:0]               byte_cnt;
  logic [HDR_LEN-2:0][7:0]  sreg;
  logic [HDR_LEN-1:0][7:0]  hdr_bytes;
  logic                     beacon;

  assign hdr_bytes = {sreg, rx_strm.dat};

  // The valid byte that completes the header.
  assign beacon = rx_strm.val && !rx_strm.sof && byte_cnt == HDR_BYTES - 5'd1;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      byte_cnt <= '0;
      hdr_val  <= 1'b0;
    end else begin
      hdr_val <= beacon;
      if (rx_strm.val) begin
        if (rx_strm.sof) begin
          byte_cnt <= 5'd1;
        end else if (byte_cnt != '0 && byte_cnt != HDR_BYTES) begin
          byte_cnt <= byte_cnt + 5'd1;
        end
        if (rx_strm.eof) begin
          byte_cnt <= '0;  // A short frame is dropped here.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_strm.val) begin
      sreg <= hdr_bytes[HDR_LEN-2:0];
    end
    // Byte 27 of hdr_bytes is the first byte on the wire.
    if (beacon) begin
      rx_hdr.oper <= hdr_bytes[21:20];
      rx_hdr.sha  <= hdr_bytes[19:14];
      rx_hdr.spa  <= hdr_bytes[13:10];
      rx_hdr.tha  <= hdr_bytes[9:4];
      rx_hdr.tpa  <= hdr_bytes[3:0];
    end
  end

  a_sof_has_val : assert property (
    @(posedge clk) disable iff (fsm_rst)
    rx_strm.sof |-> rx_strm.val
  );

endmodule : arp_rx

/* rtl/arp_table.sv */
`timescale 1ns/10ps

module arp_table #(
  parameter int TABLE_DEPTH = 4
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                learn_val,
  input  eth_pkg::mac_addr_t  learn_mac,
  input  eth_pkg::ipv4_addr_t learn_ipv4,
  input  logic                lookup_val,
  input  eth_pkg::ipv4_addr_t lookup_ipv4,
  output logic                lookup_done,
  output logic                lookup_hit,
  output eth_pkg::mac_addr_t  lookup_mac
);

  localparam int PTR_W = (TABLE_DEPTH > 1) ? $clog2(TABLE_DEPTH) : 1;

  logic [TABLE_DEPTH-1:0] ent_val;
  eth_pkg::ipv4_addr_t    ent_ipv4 [TABLE_DEPTH];
  eth_pkg::mac_addr_t     ent_mac  [TABLE_DEPTH];

  logic [TABLE_DEPTH-1:0] learn_match;
  logic [TABLE_DEPTH-1:0] lookup_match;
  logic [TABLE_DEPTH-1:0] wr_sel;
  logic [PTR_W-1:0]       wr_ptr;
  eth_pkg::mac_addr_t     match_mac;

  always_comb begin
    match_mac = '0;
    for (int i = 0; i < TABLE_DEPTH; i++) begin
      learn_match[i]  = ent_val[i] && ent_ipv4[i] == learn_ipv4;
      lookup_match[i] = ent_val[i] && ent_ipv4[i] == lookup_ipv4;
      if (lookup_match[i]) begin
        match_mac = ent_mac[i];
      end
    end
  end

  // A known address is refreshed in place, a new one takes the round-robin slot.
  always_comb begin
    wr_sel = '0;
    if (learn_val) begin
      if (|learn_match) wr_sel = learn_match;
      else wr_sel[wr_ptr] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      ent_val     <= '0;
      wr_ptr      <= '0;
      lookup_done <= 1'b0;
      lookup_hit  <= 1'b0;
    end else begin
      ent_val     <= ent_val | wr_sel;
      lookup_done <= lookup_val;
      lookup_hit  <= lookup_val && |lookup_match;
      if (learn_val && !(|learn_match)) begin
        if (wr_ptr == PTR_W'(TABLE_DEPTH - 1)) wr_ptr <= '0;
        else wr_ptr <= wr_ptr + PTR_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < TABLE_DEPTH; i++) begin
      if (wr_sel[i]) begin
        ent_ipv4[i] <= learn_ipv4;
        ent_mac[i]  <= learn_mac;
      end
    end
    lookup_mac <= match_mac;  // Reads the contents from before a same-cycle learn.
  end

  a_unique_entry : assert property (
    @(posedge clk) disable iff (fsm_rst)
    $onehot0(lookup_match)
  );

endmodule : arp_table

/* rtl/arp_ctrl.sv */
`timescale 1ns/10ps

module arp_ctrl (
  input  logic                clk,
  input  logic                fsm_rst,
  input  eth_pkg::dev_t       dev,
  input  logic                hdr_val,
  input  arp_pkg::arp_hdr_t   rx_hdr,
  input  eth_pkg::ipv4_addr_t lookup_ipv4,
  input  logic                lookup_done,
  input  logic                lookup_hit,
  output logic                job_val,
  output arp_pkg::arp_job_t   job,
  input  logic                job_ack
);

  typedef enum logic {
    idle_s,
    offer_s
  } state_t;

  state_t              state;
  logic                rep_pend;
  logic                req_pend;
  arp_pkg::arp_job_t   rep_job;
  arp_pkg::arp_job_t   req_job;
  eth_pkg::ipv4_addr_t lookup_ipv4_q;  // Address of the lookup that lookup_done answers.
  logic                reply_due;
  logic                request_due;
  logic                load_rep;
  logic                load_req;

  assign reply_due   = hdr_val && rx_hdr.oper == arp_pkg::OPER_REQUEST &&
                       rx_hdr.tpa == dev.ipv4_addr;
  assign request_due = lookup_done && !lookup_hit;

  // Replies go first.
  assign load_rep = state == idle_s && rep_pend;
  assign load_req = state == idle_s && !rep_pend && req_pend;

  always_ff @(posedge clk) begin
    lookup_ipv4_q <= lookup_ipv4;
    if (reply_due) begin
      rep_job.oper    <= arp_pkg::OPER_REPLY;
      rep_job.dst_mac <= rx_hdr.sha;
      rep_job.tha     <= rx_hdr.sha;
      rep_job.tpa     <= rx_hdr.spa;
    end
    if (request_due) begin
      req_job.oper    <= arp_pkg::OPER_REQUEST;
      req_job.dst_mac <= eth_pkg::BROADCAST_MAC;
      req_job.tha     <= '0;
      req_job.tpa     <= lookup_ipv4_q;
    end
    if (load_rep) job <= rep_job;
    else if (load_req) job <= req_job;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= idle_s;
      rep_pend <= 1'b0;
      req_pend <= 1'b0;
      job_val  <= 1'b0;
    end else begin
      case (state)
        idle_s : begin
          if (load_rep || load_req) begin
            job_val <= 1'b1;
            state   <= offer_s;
          end
          if (load_rep) rep_pend <= 1'b0;
          if (load_req) req_pend <= 1'b0;
        end
        offer_s : begin
          if (job_ack) begin
            job_val <= 1'b0;
            state   <= idle_s;
          end
        end
        default : state <= idle_s;
      endcase
      // A new event refills its slot even in the cycle the old one is taken.
      if (reply_due) rep_pend <= 1'b1;
      if (request_due) req_pend <= 1'b1;
    end
  end

  a_job_stable : assert property (
    @(posedge clk) disable iff (fsm_rst)
    job_val && !job_ack |=> $stable(job)
  );

endmodule : arp_ctrl

/* rtl/arp_tx.sv */
`timescale 1ns/10ps

module arp_tx (
  input  logic               clk,
  input  logic               fsm_rst,
  input  eth_pkg::dev_t      dev,
  input  logic               job_val,
  input  arp_pkg::arp_job_t  job,
  output logic               job_ack,
  output eth_pkg::mac_meta_t tx_meta,
  output logic               tx_rdy,
  input  logic               tx_req,
  output eth_pkg::stream_t   tx_strm
);

  typedef enum logic [1:0] {
    idle_s,
    wait_s,
    tx_s
  } state_t;

  localparam int         HDR_LEN   = arp_pkg::ARP_HDR_LEN;
  localparam logic [5:0] LAST_BYTE = 6'(eth_pkg::MIN_PAYLOAD_LEN - 16'd1);

  state_t                  state;
  logic [HDR_LEN-1:0][7:0] data;      // Byte HDR_LEN-1 is the next one out.
  logic [5:0]              byte_cnt;
  logic                    grant;

  assign job_ack = state == idle_s && job_val;
  assign grant   = tx_req && tx_rdy;

  // ==========================================================================
  // Header and padding shift register
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (job_ack) begin
      data <= {
        16'd1,
        arp_pkg::PTYPE_IPV4,
        8'd6,
        8'd4,
        job.oper,
        dev.mac_addr,
        dev.ipv4_addr,
        job.tha,
        job.tpa
      };
      tx_meta.dst_mac   <= job.dst_mac;
      tx_meta.src_mac   <= dev.mac_addr;
      tx_meta.ethertype <= eth_pkg::ETHERTYPE_ARP;
      tx_meta.length    <= eth_pkg::MIN_PAYLOAD_LEN;
    end else if (grant || state == tx_s) begin
      data <= {data[HDR_LEN-2:0], 8'h00};  // Zeros behind the header form the pad.
    end
  end

  // ==========================================================================
  // Transmit FSM
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= idle_s;
      tx_rdy   <= 1'b0;
      tx_strm  <= '0;
      byte_cnt <= '0;
    end else begin
      tx_strm.val <= 1'b0;
      tx_strm.sof <= 1'b0;
      tx_strm.eof <= 1'b0;
      case (state)
        idle_s : begin
          if (job_ack) begin
            tx_rdy <= 1'b1;
            state  <= wait_s;
          end
        end
        wait_s : begin
          if (grant) begin
            tx_rdy      <= 1'b0;
            tx_strm.val <= 1'b1;
            tx_strm.sof <= 1'b1;
            tx_strm.dat <= data[HDR_LEN-1];
            byte_cnt    <= 6'd1;
            state       <= tx_s;
          end
        end
        tx_s : begin
          tx_strm.val <= 1'b1;
          tx_strm.dat <= data[HDR_LEN-1];
          byte_cnt    <= byte_cnt + 6'd1;
          if (byte_cnt == LAST_BYTE) begin
            tx_strm.eof <= 1'b1;
            state       <= idle_s;
          end
        end
        default : state <= idle_s;
      endcase
    end
  end

  a_eof_with_val : assert property (
    @(posedge clk) disable iff (fsm_rst)
    tx_strm.eof |-> tx_strm.val
  );

endmodule : arp_tx

/* rtl/arp_top.sv */
`timescale 1ns/10ps

module arp_top #(
  parameter int TABLE_DEPTH = 4
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  eth_pkg::dev_t       dev,
  input  eth_pkg::stream_t    rx_strm,
  input  logic                lookup_val,
  input  eth_pkg::ipv4_addr_t lookup_ipv4,
  output logic                lookup_done,
  output logic                lookup_hit,
  output eth_pkg::mac_addr_t  lookup_mac,
  output eth_pkg::mac_meta_t  tx_meta,
  output logic                tx_rdy,
  input  logic                tx_req,
  output eth_pkg::stream_t    tx_strm
);

  logic              hdr_val;
  arp_pkg::arp_hdr_t rx_hdr;
  logic              job_val;
  arp_pkg::arp_job_t job;
  logic              job_ack;

  arp_rx rx_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rx_strm (rx_strm),
    .hdr_val (hdr_val),
    .rx_hdr  (rx_hdr)
  );

  // Every received header teaches the cache its sender pair.
  arp_table #(
    .TABLE_DEPTH (TABLE_DEPTH)
  ) table_i (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .learn_val   (hdr_val),
    .learn_mac   (rx_hdr.sha),
    .learn_ipv4  (rx_hdr.spa),
    .lookup_val  (lookup_val),
    .lookup_ipv4 (lookup_ipv4),
    .lookup_done (lookup_done),
    .lookup_hit  (lookup_hit),
    .lookup_mac  (lookup_mac)
  );

  arp_ctrl ctrl_i (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev         (dev),
    .hdr_val     (hdr_val),
    .rx_hdr      (rx_hdr),
    .lookup_ipv4 (lookup_ipv4),
    .lookup_done (lookup_done),
    .lookup_hit  (lookup_hit),
    .job_val     (job_val),
    .job         (job),
    .job_ack     (job_ack)
  );

  arp_tx tx_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .dev     (dev),
    .job_val (job_val),
    .job     (job),
    .job_ack (job_ack),
    .tx_meta (tx_meta),
    .tx_rdy  (tx_rdy),
    .tx_req  (tx_req),
    .tx_strm (tx_strm)
  );

endmodule : arp_top

/* tests/arp_tb.sv */
`timescale 1ns/10ps

module arp_tb;

  localparam int          CLK_PERIOD = 20;
  localparam int          MAX_TESTS  = 32;
  localparam int          FRAME_LEN  = 46;
  localparam logic [47:0] DEV_MAC    = 48'h021a_2b3c_4d5e;
  localparam logic [31:0] DEV_IPV4   = 32'hc0a8_0001;

  logic                clk;
  logic                fsm_rst;
  eth_pkg::dev_t       dev;
  eth_pkg::stream_t    rx_strm;
  logic                lookup_val;
  eth_pkg::ipv4_addr_t lookup_ipv4;
  logic                lookup_done;
  logic                lookup_hit;
  eth_pkg::mac_addr_t  lookup_mac;
  eth_pkg::mac_meta_t  tx_meta;
  logic                tx_rdy;
  logic                tx_req;
  eth_pkg::stream_t    tx_strm;

  logic [31:0] kind_tab    [MAX_TESTS];
  logic [47:0] mac_tab     [MAX_TESTS];
  logic [31:0] ipv4_tab    [MAX_TESTS];
  logic [31:0] tpa_tab     [MAX_TESTS];
  logic        hit_tab     [MAX_TESTS];
  logic [47:0] exp_mac_tab [MAX_TESTS];
  logic        frame_tab   [MAX_TESTS];
  int          n_tests;
  logic        stim_loaded;

  logic [7:0]   exp_bytes [FRAME_LEN];
  logic [127:0] exp_meta;
  int           test_errs;
  int           pass_cnt;
  int           fail_cnt;
  int unsigned  seed;

  arp_top #(
    .TABLE_DEPTH (4)
  ) dut_i (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev         (dev),
    .rx_strm     (rx_strm),
    .lookup_val  (lookup_val),
    .lookup_ipv4 (lookup_ipv4),
    .lookup_done (lookup_done),
    .lookup_hit  (lookup_hit),
    .lookup_mac  (lookup_mac),
    .tx_meta     (tx_meta),
    .tx_rdy      (tx_rdy),
    .tx_req      (tx_req),
    .tx_strm     (tx_strm)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %0h expected %0h", name, got, exp);
      test_errs++;
    end
  endtask

  // Frame from the device: fixed ARP prefix, our own sender pair, then padding.
  task automatic build_expected(input logic [15:0] oper, input logic [47:0] dst,
                                input logic [47:0] tha, input logic [31:0] tpa);
    logic [223:0] hdr;
    hdr = {16'h0001, 16'h0800, 8'h06, 8'h04, oper, DEV_MAC, DEV_IPV4, tha, tpa};
    for (int i = 0; i < FRAME_LEN; i++) begin
      if (i < 28) exp_bytes[i] = hdr[223 - 8 * i -: 8];
      else exp_bytes[i] = 8'h00;
    end
    exp_meta = {dst, DEV_MAC, 16'h0806, 16'd46};
  endtask

  task automatic drive_rx_frame(input logic [47:0] sha, input logic [31:0] spa,
                                input logic [31:0] tpa, input int nbytes);
    logic [223:0] hdr;
    logic [7:0]   b;
    hdr = {16'h0001, 16'h0800, 8'h06, 8'h04, 16'h0001, sha, spa, 48'h0, tpa};
    for (int i = 0; i < nbytes; i++) begin
      repeat ($urandom % 2) begin  // Idle gap between bytes.
        @(posedge clk);
        #2;
        rx_strm = '0;
      end
      if (i < 28) b = hdr[223 - 8 * i -: 8];
      else b = 8'h00;
      @(posedge clk);
      #2;
      rx_strm.val = 1'b1;
      rx_strm.sof = (i == 0);
      rx_strm.eof = (i == nbytes - 1);
      rx_strm.dat = b;
    end
    @(posedge clk);
    #2;
    rx_strm = '0;
  endtask

  task automatic run_lookup(input logic [31:0] ipv4, input logic exp_hit,
                            input logic [47:0] exp_mac);
    @(posedge clk);
    #2;
    lookup_val  = 1'b1;
    lookup_ipv4 = ipv4;
    @(negedge clk);
    check_value("lookup_done", lookup_done, 1'b0);  // Must not answer early.
    @(posedge clk);
    #2;
    lookup_val = 1'b0;
    @(negedge clk);
    check_value("lookup_done", lookup_done, 1'b1);
    check_value("lookup_hit", lookup_hit, exp_hit);
    if (exp_hit) check_value("lookup_mac", lookup_mac, exp_mac);
  endtask

  task automatic expect_no_frame();
    logic seen;
    seen = 1'b0;
    repeat (30) begin
      @(negedge clk);
      if (tx_rdy || tx_strm.val) seen = 1'b1;
    end
    if (seen) begin
      $display("Unexpected frame: tx_rdy or tx_strm.val went high");
      test_errs++;
    end
  endtask

  task automatic collect_frame();
    int waited;
    int hold;
    waited = 0;
    @(negedge clk);
    while (!tx_rdy && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (!tx_rdy) begin
      $display("Expected frame never came: tx_rdy stayed low");
      test_errs++;
    end else begin
      check_value("tx_meta", tx_meta, exp_meta);
      hold = 1 + $urandom % 12;  // MAC holds off the grant.
      repeat (hold) begin
        @(posedge clk);
        @(negedge clk);
        if (!tx_rdy || tx_strm.val) begin
          $display("tx_rdy dropped or a byte came out before the grant");
          test_errs++;
        end
      end
      @(posedge clk);
      #2;
      tx_req = 1'b1;
      @(posedge clk);
      #2;
      tx_req = 1'b0;
      for (int i = 0; i < FRAME_LEN; i++) begin
        @(negedge clk);
        if (i == 0) check_value("tx_rdy", tx_rdy, 1'b0);
        if (tx_strm.val !== 1'b1 || tx_strm.sof !== (i == 0) ||
            tx_strm.eof !== (i == FRAME_LEN - 1)) begin
          $display("ERROR tx_strm byte %0d got val,sof,eof %h,%h,%h expected 1,%h,%h",
                   i, tx_strm.val, tx_strm.sof, tx_strm.eof, i == 0, i == FRAME_LEN - 1);
          test_errs++;
        end
        if (tx_strm.dat !== exp_bytes[i]) begin
          $display("ERROR tx_strm.dat byte %0d got %h expected %h",
                   i, tx_strm.dat, exp_bytes[i]);
          test_errs++;
        end
      end
    end
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    int               fd;
    int               code;
    logic [31:0]      kind;
    logic [8*200-1:0] line;
    logic [47:0]      f_mac;
    logic [47:0]      f_exp;
    logic [31:0]      f_ip;
    logic [31:0]      f_tpa;
    logic [3:0]       f_hit;
    logic [3:0]       f_frame;
    string            desc;
    seed        = 32'hef44_0f64;
    code        = $urandom(seed);
    fsm_rst     = 1'b1;
    dev         = {DEV_MAC, DEV_IPV4};
    rx_strm     = '0;
    lookup_val  = 1'b0;
    lookup_ipv4 = '0;
    tx_req      = 1'b0;
    n_tests     = 0;
    stim_loaded = 1'b0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    repeat (5) @(posedge clk);
    #2;
    fsm_rst = 1'b0;

    fd = $fopen("tests/arp_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file tests/arp_stimulus.txt");
      fail_cnt++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", kind);
        if (code == 1 && kind == "#") begin
          code = $fgets(line, fd);  // Column description.
        end else if (code == 1 && n_tests < MAX_TESTS) begin
          code = $fscanf(fd, "%h %h %h %h %h %h", f_mac, f_ip, f_tpa, f_hit, f_exp, f_frame);
          kind_tab[n_tests]    = kind;
          mac_tab[n_tests]     = f_mac;
          ipv4_tab[n_tests]    = f_ip;
          tpa_tab[n_tests]     = f_tpa;
          hit_tab[n_tests]     = f_hit[0];
          exp_mac_tab[n_tests] = f_exp;
          frame_tab[n_tests]   = f_frame[0];
          n_tests++;
        end
      end
      $fclose(fd);
      stim_loaded = 1'b1;
    end

    for (int t = 0; t < n_tests; t++) begin
      test_errs = 0;
      if (kind_tab[t] == "lk") begin
        desc = "lookup";
        run_lookup(ipv4_tab[t], hit_tab[t], exp_mac_tab[t]);
        build_expected(16'd1, 48'hffff_ffff_ffff, 48'h0, ipv4_tab[t]);  // Broadcast request.
      end else begin
        desc = (kind_tab[t] == "tr") ? "short frame" : "rx frame";
        drive_rx_frame(mac_tab[t], ipv4_tab[t], tpa_tab[t], (kind_tab[t] == "tr") ? 20 : 46);
        build_expected(16'd2, mac_tab[t], mac_tab[t], ipv4_tab[t]);
      end
      if (frame_tab[t]) collect_frame();
      else expect_no_frame();
      if (test_errs == 0) pass_cnt++;
      else fail_cnt++;
      $display("Test %0d %s: %s", t + 1, desc, (test_errs == 0) ? "passed" : "failed");
    end

    $display("%0d tests run, %0d passed, %0d failed", n_tests, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && n_tests > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (stim_loaded);
    #(n_tests * 200 * CLK_PERIOD);
    $display("Watchdog timeout: the tests did not finish within %0d cycles", n_tests * 200);
    $display("TESTS FAILED");
    $finish;
  end

endmodule : arp_tb

/* src.f */
rtl/eth_pkg.sv
rtl/arp_pkg.sv
rtl/arp_rx.sv
rtl/arp_table.sv
rtl/arp_ctrl.sv
rtl/arp_tx.sv
rtl/arp_top.sv
tests/arp_tb.sv

/* tests/arp_stimulus.txt */
# kind sender_mac ipv4 target_ipv4 exp_hit exp_mac exp_frame (all hex).
# Kinds: rx = request frame, tr = request cut after 20 bytes, lk = lookup of the ipv4 column.
rx 001122334401 c0a80010 c0a80001 0 000000000000 1
rx 001122334402 c0a80011 c0a80063 0 000000000000 0
lk 000000000000 c0a80011 00000000 1 001122334402 0
lk 000000000000 c0a80099 00000000 0 000000000000 1
rx 001122334403 c0a80012 c0a80063 0 000000000000 0
rx 001122334404 c0a80013 c0a80063 0 000000000000 0
rx 00aabbccdd02 c0a80011 c0a80063 0 000000000000 0
lk 000000000000 c0a80010 00000000 1 001122334401 0
rx 001122334405 c0a80014 c0a80063 0 000000000000 0
lk 000000000000 c0a80010 00000000 0 000000000000 1
lk 000000000000 c0a80011 00000000 1 00aabbccdd02 0
lk 000000000000 c0a80012 00000000 1 001122334403 0
lk 000000000000 c0a80013 00000000 1 001122334404 0
lk 000000000000 c0a80014 00000000 1 001122334405 0
tr 001122334406 c0a80015 c0a80001 0 000000000000 0
lk 000000000000 c0a80015 00000000 0 000000000000 1
rx 001122334407 c0a80016 c0a80001 0 000000000000 1
